/* filelist.f */
src/addrTypesPkg.sv
src/recoveryTypesPkg.sv
src/recoveryManager.sv
src/trapUnit.sv
src/flushWalker.sv
src/recoveryTop.sv
tb/recoveryTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the recovery testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module recoveryTb -o recoveryTbSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/recoveryTbSim)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi

echo "simulation did not pass"
exit 1

/* tb/recoveryTb.sv */
// --------------------------------------------------
// testbench for the recovery back end: random commit
// and write stage requests checked against a model
// --------------------------------------------------

`timescale 1ns/1ps

module recoveryTb;
    import addrTypesPkg::*;
    import recoveryTypesPkg::*;

    localparam int numTests    = 60;
    localparam int resetCycles = 16;
    localparam int worstCycles = 20;

    logic                 clk;
    logic                 rstN;
    cmRequest             cmReq;
    rwRequest             rwReq;
    alPointers            alPtrs;
    csrWrite              csrWr;
    logic                 replayBusy;
    pipelinePhase         phase;
    logic                 toRecoveryPhase;
    logic                 toCommitPhase;
    logic                 unableToStartRecovery;
    pcPath                recoveredPc;
    brHistoryPath         recoveredBrHistory;
    flushRange            range;
    alIndexPath           loadQueueRecoveryTail;
    alIndexPath           storeQueueRecoveryTail;
    perfEvents            events;
    trapState             trapRegs;
    alIndexPath           rmtWalkPtr;
    alIndexPath           iqWalkPtr;

    // model state
    pcPath    mtvec;
    trapState expTrap;
    int       errors;

    recoveryTop i_recoveryTop (
        .clk                    (clk),
        .rstN                   (rstN),
        .cmReq                  (cmReq),
        .rwReq                  (rwReq),
        .alPtrs                 (alPtrs),
        .csrWr                  (csrWr),
        .replayBusy             (replayBusy),
        .phase                  (phase),
        .toRecoveryPhase        (toRecoveryPhase),
        .toCommitPhase          (toCommitPhase),
        .unableToStartRecovery  (unableToStartRecovery),
        .recoveredPc            (recoveredPc),
        .recoveredBrHistory     (recoveredBrHistory),
        .range                  (range),
        .loadQueueRecoveryTail  (loadQueueRecoveryTail),
        .storeQueueRecoveryTail (storeQueueRecoveryTail),
        .events                 (events),
        .trapRegs               (trapRegs),
        .rmtWalkPtr             (rmtWalkPtr),
        .iqWalkPtr              (iqWalkPtr)
    );

    always #50 clk = ~clk;

    task automatic comparePc(input string name, input pcPath exp, input pcPath act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compareHistory(input string name, input brHistoryPath exp,
                                  input brHistoryPath act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compareIndex(input string name, input alIndexPath exp,
                                input alIndexPath act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic comparePhase(input string name, input pipelinePhase exp,
                                input pipelinePhase act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %s actual %s", $time, name,
                     exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic compareTrap(input string name, input trapState exp, input trapState act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %h/%0d/%h actual %h/%0d/%h", $time,
                     name, exp.mepc, exp.mcause, exp.mtval, act.mepc, act.mcause, act.mtval);
            errors++;
        end
    endtask

    task automatic compareEvents(input string name, input perfEvents exp,
                                 input perfEvents act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compareFlag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic compareCount(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    // one request, from setup to the return to commit
    task automatic runRecovery(input int testNum);
        int           src;
        int           waitCycles;
        int           cycles;
        int           pulses;
        int           n;
        int           startErrors;
        pcPath        pc;
        refetchType   kind;
        trapCause     cause;
        addrPath      dataAddr;
        brHistoryPath hist;
        flushRange    expRange;
        perfEvents    expEvents;
        pcPath        expPc;
        logic         csrRef;
        alIndexPath   expStoreTail;

        startErrors = errors;
        replayBusy  = 1'($urandom % 2);
        @(negedge clk);
        compareFlag("unableToStartRecovery", replayBusy, unableToStartRecovery);
        replayBusy = 1'b0;
        waitCycles = 0;
        while (unableToStartRecovery && waitCycles < 30) begin
            @(negedge clk);
            waitCycles++;
        end
        if (unableToStartRecovery) begin
            $display("test %0d: recovery never became possible", testNum);
            errors++;
        end

        csrWr.valid = 1'b1;
        csrWr.data  = $urandom;
        mtvec       = csrWr.data;
        @(negedge clk);
        csrWr.valid = 1'b0;

        // 0 commit only, 1 write stage only, 2 both
        src = $urandom % 3;
        alPtrs.exceptionOpPtr = alIndexPath'($urandom);
        alPtrs.flushTailPtr   = alIndexPath'($urandom);
        alPtrs.loadQueueTail  = alIndexPath'($urandom);
        alPtrs.storeQueueTail = alIndexPath'($urandom);
        rwReq.valid     = (src != 0);
        rwReq.pc        = $urandom;
        rwReq.refetch   = refetchType'($urandom % 4);
        rwReq.brHistory = brHistoryPath'($urandom);
        cmReq.valid     = (src != 1);
        cmReq.pc        = $urandom;
        cmReq.refetch   = refetchType'($urandom % 6);
        cmReq.dataAddr  = $urandom;
        cmReq.brHistory = brHistoryPath'($urandom);
        if (cmReq.refetch inside {refetchNextPcToCsr, refetchThisPcToCsr}) begin
            cmReq.cause = trapCause'(1 + $urandom % 4);
        end else begin
            cmReq.cause = causeNone;
        end

        if (cmReq.valid) begin
            pc       = cmReq.pc;
            kind     = cmReq.refetch;
            hist     = cmReq.brHistory;
            cause    = cmReq.cause;
            dataAddr = cmReq.dataAddr;
        end else begin
            pc       = rwReq.pc;
            kind     = rwReq.refetch;
            hist     = rwReq.brHistory;
            cause    = causeNone;
            dataAddr = '0;
        end
        csrRef = (kind == refetchNextPcToCsr) || (kind == refetchThisPcToCsr);
        if (kind == refetchThisPc || kind == refetchThisPcToCsr) begin
            expRange.headPtr = alPtrs.exceptionOpPtr;
        end else begin
            expRange.headPtr = alPtrs.exceptionOpPtr + 4'd1;
        end
        expRange.tailPtr = alPtrs.flushTailPtr;
        n = int'(alIndexPath'(expRange.tailPtr - expRange.headPtr));
        if (kind == refetchNextPc || kind == refetchStoreNextPc) begin
            expPc = pc + 32'd4;
        end else if (csrRef) begin
            expPc = (cause == causeMret) ? expTrap.mepc : mtvec;
        end else begin
            expPc = pc;
        end
        expStoreTail = alPtrs.storeQueueTail + ((kind == refetchStoreNextPc) ? 4'd1 : 4'd0);
        expEvents.forwardFail = (kind == refetchThisPc);
        expEvents.memDepMiss  = (kind == refetchNextPc) || (kind == refetchStoreNextPc);
        expEvents.branchMiss  = (kind == refetchBranchTarget);

        // recover-0
        @(negedge clk);
        cmReq.valid = 1'b0;
        rwReq.valid = 1'b0;
        comparePhase("phase", phaseRecover0, phase);
        compareFlag("toRecoveryPhase", 1'b1, toRecoveryPhase);
        compareFlag("unableToStartRecovery", 1'b1, unableToStartRecovery);
        comparePc("recoveredPc", expPc, recoveredPc);
        compareHistory("recoveredBrHistory", hist, recoveredBrHistory);
        compareIndex("range.headPtr", expRange.headPtr, range.headPtr);
        compareIndex("range.tailPtr", expRange.tailPtr, range.tailPtr);
        compareIndex("loadQueueRecoveryTail", alPtrs.loadQueueTail, loadQueueRecoveryTail);
        compareIndex("storeQueueRecoveryTail", expStoreTail, storeQueueRecoveryTail);
        compareEvents("events", expEvents, events);
        if (csrRef && cause != causeMret) begin
            expTrap.mepc   = pc;
            expTrap.mcause = cause;
            expTrap.mtval  = dataAddr;
        end

        // a late request during recovery must be dropped
        // other head rule, so a wrong accept moves the range head
        cmReq.valid = ($urandom % 2 == 0);
        cmReq.pc    = $urandom;
        if (kind == refetchThisPc || kind == refetchThisPcToCsr) begin
            cmReq.refetch = refetchNextPc;
        end else begin
            cmReq.refetch = refetchThisPc;
        end
        cmReq.cause = causeNone;

        @(negedge clk);
        cmReq.valid = 1'b0;
        compareTrap("trapRegs", expTrap, trapRegs);
        compareIndex("rmtWalkPtr", expRange.headPtr, rmtWalkPtr);
        compareIndex("iqWalkPtr", expRange.headPtr, iqWalkPtr);
        compareEvents("events", '0, events);

        cycles = 0;
        pulses = 0;
        while (phase == phaseRecover1 && cycles < worstCycles) begin
            compareFlag("unableToStartRecovery", 1'b1, unableToStartRecovery);
            compareFlag("toRecoveryPhase", 1'b0, toRecoveryPhase);
            comparePc("recoveredPc", '0, recoveredPc);
            compareIndex("range.headPtr", expRange.headPtr, range.headPtr);
            if (toCommitPhase) begin
                pulses++;
            end
            cycles++;
            @(negedge clk);
        end
        comparePhase("phase", phaseCommit, phase);
        compareCount("recover-1 cycles", (n + 1) / 2 + 1, cycles);
        compareCount("toCommitPhase pulses", 1, pulses);
        compareFlag("toCommitPhase", 1'b0, toCommitPhase);

        if (errors == startErrors) begin
            $display("test %0d: ok (%s, %0d entries)", testNum, kind.name(), n);
        end else begin
            $display("test %0d: %0d errors", testNum, errors - startErrors);
        end
    endtask

    // watchdog
    initial begin
        #((numTests * worstCycles + resetCycles) * 100);
        $display("run timed out before all tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h7848e930));
        clk        = 1'b0;
        rstN       = 1'b0;
        cmReq      = '0;
        rwReq      = '0;
        alPtrs     = '0;
        csrWr      = '0;
        replayBusy = 1'b0;
        mtvec      = '0;
        expTrap    = '0;
        errors     = 0;
        repeat (resetCycles) @(negedge clk);
        comparePhase("phase", phaseCommit, phase);
        compareTrap("trapRegs", expTrap, trapRegs);
        compareEvents("events", '0, events);
        compareFlag("toRecoveryPhase", 1'b0, toRecoveryPhase);
        rstN = 1'b1;
        for (int t = 0; t < numTests; t++) begin
            runRecovery(t);
        end
        $display("%0d tests run, %0d errors", numTests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : recoveryTb

/* src/recoveryTop.sv */
// --------------------------------------------------
// recovery back end: manager, trap unit, and walkers
// for the rename map and the issue queue
// --------------------------------------------------

`timescale 1ns/1ps

module recoveryTop (
    input  logic                           clk,
    input  logic                           rstN,
    input  recoveryTypesPkg::cmRequest     cmReq,
    input  recoveryTypesPkg::rwRequest     rwReq,
    input  recoveryTypesPkg::alPointers    alPtrs,
    input  recoveryTypesPkg::csrWrite      csrWr,
    input  logic                           replayBusy,
    output recoveryTypesPkg::pipelinePhase phase,
    output logic                           toRecoveryPhase,
    output logic                           toCommitPhase,
    output logic                           unableToStartRecovery,
    output addrTypesPkg::pcPath            recoveredPc,
    output addrTypesPkg::brHistoryPath     recoveredBrHistory,
    output recoveryTypesPkg::flushRange    range,
    output recoveryTypesPkg::alIndexPath   loadQueueRecoveryTail,
    output recoveryTypesPkg::alIndexPath   storeQueueRecoveryTail,
    output recoveryTypesPkg::perfEvents    events,
    output recoveryTypesPkg::trapState     trapRegs,
    output recoveryTypesPkg::alIndexPath   rmtWalkPtr,
    output recoveryTypesPkg::alIndexPath   iqWalkPtr
);
    import addrTypesPkg::*;
    import recoveryTypesPkg::*;

    trapRequest trapReq;
    pcPath      trapTarget;
    logic       rmtBusy;
    logic       iqBusy;

    recoveryManager i_recoveryManager (
        .clk                    (clk),
        .rstN                   (rstN),
        .cmReq                  (cmReq),
        .rwReq                  (rwReq),
        .alPtrs                 (alPtrs),
        .trapTarget             (trapTarget),
        .rmtBusy                (rmtBusy),
        .iqBusy                 (iqBusy),
        .replayBusy             (replayBusy),
        .phase                  (phase),
        .toRecoveryPhase        (toRecoveryPhase),
        .toCommitPhase          (toCommitPhase),
        .unableToStartRecovery  (unableToStartRecovery),
        .trapReq                (trapReq),
        .range                  (range),
        .recoveredPc            (recoveredPc),
        .recoveredBrHistory     (recoveredBrHistory),
        .loadQueueRecoveryTail  (loadQueueRecoveryTail),
        .storeQueueRecoveryTail (storeQueueRecoveryTail),
        .events                 (events)
    );

    trapUnit i_trapUnit (
        .clk        (clk),
        .rstN       (rstN),
        .req        (trapReq),
        .wr         (csrWr),
        .trapTarget (trapTarget),
        .state      (trapRegs)
    );

    // rename map restore
    flushWalker #(.walkWidth(2)) i_rmtWalker (
        .clk     (clk),
        .rstN    (rstN),
        .start   (toRecoveryPhase),
        .range   (range),
        .busy    (rmtBusy),
        .walkPtr (rmtWalkPtr)
    );

    // issue queue index return
    flushWalker #(.walkWidth(4)) i_iqWalker (
        .clk     (clk),
        .rstN    (rstN),
        .start   (toRecoveryPhase),
        .range   (range),
        .busy    (iqBusy),
        .walkPtr (iqWalkPtr)
    );

endmodule : recoveryTop

/* src/flushWalker.sv */
// --------------------------------------------------
// walks a flushed active-list range, walkWidth entries
// per cycle; busy stays high until the walk is done
// --------------------------------------------------

`timescale 1ns/1ps

module flushWalker #(
    parameter int walkWidth = 2
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         start,
    input  recoveryTypesPkg::flushRange  range,
    output logic                         busy,
    output recoveryTypesPkg::alIndexPath walkPtr
);
    import recoveryTypesPkg::*;

    // entries still to walk
    alIndexPath remaining;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remaining <= '0;
            walkPtr   <= '0;
        end else if (start) begin
            // wraps mod 16
            remaining <= range.tailPtr - range.headPtr;
            walkPtr   <= range.headPtr;
        end else if (busy) begin
            walkPtr <= walkPtr + alIndexPath'(walkWidth);
            if (remaining > alIndexPath'(walkWidth)) begin
                remaining <= remaining - alIndexPath'(walkWidth);
            end else begin
                remaining <= '0;
            end
        end
    end

    assign busy = (remaining != '0);

endmodule : flushWalker

/* src/trapUnit.sv */
// --------------------------------------------------
// machine-mode trap registers; gives the trap or mret
// target to the recovery manager and records the trap
// --------------------------------------------------

`timescale 1ns/1ps

module trapUnit (
    input  logic                         clk,
    input  logic                         rstN,
    input  recoveryTypesPkg::trapRequest req,
    input  recoveryTypesPkg::csrWrite    wr,
    output addrTypesPkg::pcPath          trapTarget,
    output recoveryTypesPkg::trapState   state
);
    import addrTypesPkg::*;
    import recoveryTypesPkg::*;

    pcPath    mtvec;
    pcPath    mepc;
    trapCause mcause;
    addrPath  mtval;

    logic isMret;

    assign isMret = (req.cause == causeMret);

    // mret returns to the saved PC
    assign trapTarget = isMret ? mepc : mtvec;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mtvec <= '0;
        end else if (wr.valid) begin
            mtvec <= wr.data;
        end
    end

    // record on a real trap only
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mepc   <= '0;
            mcause <= causeNone;
            mtval  <= '0;
        end else if (req.trigger && !isMret) begin
            mepc   <= req.causePc;
            mcause <= req.cause;
            mtval  <= req.dataAddr;
        end
    end

    assign state.mepc   = mepc;
    assign state.mcause = mcause;
    assign state.mtval  = mtval;

endmodule : trapUnit

/* src/recoveryManager.sv */
// --------------------------------------------------
// recovery phase controller: accepts a commit or write
// stage request, broadcasts recover-0, computes the
// refetch PC and flush range, waits on the walkers
// --------------------------------------------------

`timescale 1ns/1ps

module recoveryManager (
    input  logic                           clk,
    input  logic                           rstN,
    input  recoveryTypesPkg::cmRequest     cmReq,
    input  recoveryTypesPkg::rwRequest     rwReq,
    input  recoveryTypesPkg::alPointers    alPtrs,
    input  addrTypesPkg::pcPath            trapTarget,
    input  logic                           rmtBusy,
    input  logic                           iqBusy,
    input  logic                           replayBusy,
    output recoveryTypesPkg::pipelinePhase phase,
    output logic                           toRecoveryPhase,
    output logic                           toCommitPhase,
    output logic                           unableToStartRecovery,
    output recoveryTypesPkg::trapRequest   trapReq,
    output recoveryTypesPkg::flushRange    range,
    output addrTypesPkg::pcPath            recoveredPc,
    output addrTypesPkg::brHistoryPath     recoveredBrHistory,
    output recoveryTypesPkg::alIndexPath   loadQueueRecoveryTail,
    output recoveryTypesPkg::alIndexPath   storeQueueRecoveryTail,
    output recoveryTypesPkg::perfEvents    events
);
    import addrTypesPkg::*;
    import recoveryTypesPkg::*;

    // request as latched at acceptance, source already resolved
    typedef struct packed {
        pcPath        pc;
        refetchType   refetch;
        trapCause     cause;
        addrPath      dataAddr;
        brHistoryPath brHistory;
        flushRange    range;
    } recoveryState;

    recoveryState regReq;
    recoveryState nextReq;
    pipelinePhase nextPhase;

    logic accept;
    logic inRecover0;
    logic csrRefetch;
    logic walkersBusy;

    assign walkersBusy = rmtBusy || iqBusy;

    // only the commit phase takes new requests
    assign accept = (phase == phaseCommit) && (cmReq.valid || rwReq.valid);

    // commit stage wins on a simultaneous request
    always_comb begin
        if (cmReq.valid) begin
            nextReq.pc        = cmReq.pc;
            nextReq.refetch   = cmReq.refetch;
            nextReq.brHistory = cmReq.brHistory;
            nextReq.cause     = cmReq.cause;
            nextReq.dataAddr  = cmReq.dataAddr;
        end else begin
            nextReq.pc        = rwReq.pc;
            nextReq.refetch   = rwReq.refetch;
            nextReq.brHistory = rwReq.brHistory;
            nextReq.cause     = causeNone;
            nextReq.dataAddr  = '0;
        end

        // this-PC refetch flushes the faulting op too
        if (nextReq.refetch inside {refetchThisPc, refetchThisPcToCsr}) begin
            nextReq.range.headPtr = alPtrs.exceptionOpPtr;
        end else begin
            nextReq.range.headPtr = alPtrs.exceptionOpPtr + alIndexPath'(1);
        end
        nextReq.range.tailPtr = alPtrs.flushTailPtr;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            regReq <= nextReq;
        end
    end

    // phase FSM
    assign toCommitPhase = (phase == phaseRecover1) && !walkersBusy;

    always_comb begin
        case (phase)
            phaseCommit:   nextPhase = accept ? phaseRecover0 : phaseCommit;
            phaseRecover0: nextPhase = phaseRecover1;
            phaseRecover1: nextPhase = toCommitPhase ? phaseCommit : phaseRecover1;
            default:       nextPhase = phaseCommit;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase <= phaseCommit;
        end else begin
            phase <= nextPhase;
        end
    end

    assign inRecover0      = (phase == phaseRecover0);
    assign toRecoveryPhase = inRecover0;

    assign unableToStartRecovery = (phase != phaseCommit) || walkersBusy || replayBusy;

    // trap request, the target comes back combinationally
    assign csrRefetch = regReq.refetch inside {refetchNextPcToCsr, refetchThisPcToCsr};

    assign trapReq.trigger  = inRecover0 && csrRefetch;
    assign trapReq.causePc  = regReq.pc;
    assign trapReq.cause    = regReq.cause;
    assign trapReq.dataAddr = regReq.dataAddr;

    // refetch PC, zero outside recover-0
    always_comb begin
        recoveredPc = '0;
        if (inRecover0) begin
            case (regReq.refetch)
                refetchNextPc,
                refetchStoreNextPc:  recoveredPc = regReq.pc + pcPath'(insnByteWidth);
                refetchNextPcToCsr,
                refetchThisPcToCsr:  recoveredPc = trapTarget;
                default:             recoveredPc = regReq.pc;
            endcase
        end
    end

    assign recoveredBrHistory = regReq.brHistory;
    assign range              = regReq.range;

    // queue tails, the pointers are held stable during recovery
    assign loadQueueRecoveryTail = alPtrs.loadQueueTail;

    // a store refetched at next PC stays in the queue
    assign storeQueueRecoveryTail = (regReq.refetch == refetchStoreNextPc) ?
        alPtrs.storeQueueTail + alIndexPath'(1) : alPtrs.storeQueueTail;

    // perf strobes, one cycle each
    assign events.forwardFail = inRecover0 && (regReq.refetch == refetchThisPc);
    assign events.memDepMiss  = inRecover0 &&
        (regReq.refetch inside {refetchNextPc, refetchStoreNextPc});
    assign events.branchMiss  = inRecover0 && (regReq.refetch == refetchBranchTarget);

endmodule : recoveryManager

/* src/recoveryTypesPkg.sv */
// --------------------------------------------------
// recovery control types: phases, refetch kinds, trap
// causes and the structs passed between the manager,
// trap unit and flush walkers
// --------------------------------------------------

package recoveryTypesPkg;
    import addrTypesPkg::*;

    // active list depth and index
    localparam int alEntries = 16;
    typedef logic [$clog2(alEntries)-1:0] alIndexPath;

    typedef enum logic [1:0] {
        phaseCommit,
        phaseRecover0,
        phaseRecover1
    } pipelinePhase;

    typedef enum logic [2:0] {
        refetchThisPc,
        refetchNextPc,
        refetchStoreNextPc,
        refetchBranchTarget,
        refetchNextPcToCsr,
        refetchThisPcToCsr
    } refetchType;

    typedef enum logic [2:0] {
        causeNone,
        causeEcall,
        causeLoadFault,
        causeStoreFault,
        causeMret
    } trapCause;

    // request from the commit stage, may carry a trap
    typedef struct packed {
        logic         valid;
        pcPath        pc;
        refetchType   refetch;
        trapCause     cause;
        addrPath      dataAddr;
        brHistoryPath brHistory;
    } cmRequest;

    // request from the register-write stage, never a CSR refetch
    typedef struct packed {
        logic         valid;
        pcPath        pc;
        refetchType   refetch;
        brHistoryPath brHistory;
    } rwRequest;

    typedef struct packed {
        alIndexPath exceptionOpPtr;
        alIndexPath flushTailPtr;
        alIndexPath loadQueueTail;
        alIndexPath storeQueueTail;
    } alPointers;

    // tail is exclusive
    typedef struct packed {
        alIndexPath headPtr;
        alIndexPath tailPtr;
    } flushRange;

    typedef struct packed {
        logic     trigger;
        pcPath    causePc;
        trapCause cause;
        addrPath  dataAddr;
    } trapRequest;

    typedef struct packed {
        pcPath    mepc;
        trapCause mcause;
        addrPath  mtval;
    } trapState;

    typedef struct packed {
        logic  valid;
        pcPath data;
    } csrWrite;

    typedef struct packed {
        logic forwardFail;
        logic memDepMiss;
        logic branchMiss;
    } perfEvents;

endpackage : recoveryTypesPkg

/* src/addrTypesPkg.sv */
// --------------------------------------------------
// address and program counter types shared by the
// recovery logic; import where PC or history values
// are stored or computed
// --------------------------------------------------

package addrTypesPkg;

    // byte address, used for faulting data addresses
    typedef logic [31:0] addrPath;

    // program counter
    typedef logic [31:0] pcPath;

    // global branch history restored on recovery
    typedef logic [9:0] brHistoryPath;

    // step from one instruction to the next
    localparam int insnByteWidth = 4;

endpackage : addrTypesPkg
